// File: include/l2_cache_macros.svh
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// Cache geometry
`define L2_WAYS       8
`define L2_WAY_PTR_W  3
`define L2_SETS_W     4
`define L2_SETS       16

// Address split: tag | index | word offset | byte
`define L2_OFFSET_W   4
`define L2_TAG_W      22

// Line and word sizes
`define L2_LINE_W     512
`define L2_LINE_BYTES 64
`define L2_WORD_W     32

`endif

// File: design/l2_cache_pkg.sv
`default_nettype none

`include "l2_cache_macros.svh"

package l2_cache_pkg;

    typedef enum logic [1:0] {
        OP_READ   = 2'd0,
        OP_WRITE  = 2'd1,
        OP_REFILL = 2'd2
    } l2_op_e;

    // 32-bit byte address, MSB first
    typedef struct packed {
        logic [`L2_TAG_W-1:0]    tag;
        logic [`L2_SETS_W-1:0]   index;
        logic [`L2_OFFSET_W-1:0] offset;
        logic [1:0]              byte_off;
    } l2_addr_t;

    typedef struct packed {
        l2_op_e                   op;
        l2_addr_t                 addr;
        logic [`L2_WORD_W-1:0]    wdata;
        logic [`L2_WORD_W/8-1:0]  be;
    } l2_req_t;

    typedef struct packed {
        logic                  hit;
        logic [`L2_WORD_W-1:0] word;
    } l2_resp_t;

    typedef struct packed {
        logic                 valid;
        logic [`L2_TAG_W-1:0] tag;
    } l2_tag_entry_t;

    // Write port of the data array
    typedef struct packed {
        logic [`L2_SETS_W-1:0]   index;
        logic [`L2_WAYS-1:0]     way_we;
        logic                    replace;
        logic [`L2_OFFSET_W-1:0] offset;
        logic [`L2_WORD_W/8-1:0] be;
        logic [`L2_WORD_W-1:0]   word;
        logic [`L2_LINE_W-1:0]   line;
    } l2_data_wr_t;

    typedef logic [`L2_WAYS-1:0][`L2_LINE_W-1:0] l2_way_lines_t;
    typedef l2_tag_entry_t [`L2_WAYS-1:0] l2_way_tags_t;

endpackage

`default_nettype wire

// File: design/bram_bytewrite.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port RAM, one write port and one registered read port
module bram_bytewrite #(
    parameter int DATA_WIDTH = 512,
    parameter int ADDR_WIDTH = 4
) (
    input  wire logic                    clk,

    input  wire logic [ADDR_WIDTH-1:0]   waddr,
    input  wire logic [DATA_WIDTH-1:0]   din,
    input  wire logic [DATA_WIDTH/8-1:0] we,

    input  wire logic [ADDR_WIDTH-1:0]   raddr,
    output logic      [DATA_WIDTH-1:0]   dout
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Byte-masked write
    always_ff @(posedge clk) begin
        for (int b = 0; b < DATA_WIDTH/8; b++) begin
            if (we[b]) begin
                mem[waddr][b*8 +: 8] <= din[b*8 +: 8];
            end
        end
    end

    // Read-first on a same-address collision
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: design/l2_data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

// Data storage: one byte-writable RAM per way, shared read and write index
module l2_data_array (
    input  wire logic                          clk,
    input  wire logic [`L2_SETS_W-1:0]         rd_index,
    input  wire l2_cache_pkg::l2_data_wr_t     wr,
    output l2_cache_pkg::l2_way_lines_t        rd_lines
);

    localparam int WORD_BYTES = `L2_WORD_W / 8;

    logic [`L2_LINE_BYTES-1:0] line_mask;
    logic [`L2_LINE_W-1:0]     line_data;

    //////////////////////////////////////////////////
    // Write mask and data alignment
    //////////////////////////////////////////////////

    // Full line on replace, otherwise one word at its offset
    always_comb begin
        if (wr.replace) begin
            line_mask = '1;
            line_data = wr.line;
        end else begin
            line_mask = `L2_LINE_BYTES'(wr.be) << (wr.offset * WORD_BYTES);
            line_data = '0;
            line_data[wr.offset*`L2_WORD_W +: `L2_WORD_W] = wr.word;
        end
    end

    //////////////////////////////////////////////////
    // Way RAMs
    //////////////////////////////////////////////////

    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        logic [`L2_LINE_BYTES-1:0] way_mask;

        // Disabled ways get no bytes
        assign way_mask = wr.way_we[w] ? line_mask : '0;

        bram_bytewrite #(
            .DATA_WIDTH (`L2_LINE_W),
            .ADDR_WIDTH (`L2_SETS_W)
        ) ram_i (
            .clk   (clk),
            .waddr (wr.index),
            .din   (line_data),
            .we    (way_mask),
            .raddr (rd_index),
            .dout  (rd_lines[w])
        );
    end

    // A write touches at most one way
    a_way_we_onehot0: assert property (
        @(posedge clk)
        !$isunknown(wr.way_we) |-> $onehot0(wr.way_we)
    ) else $error("data write enables more than one way");

endmodule

`default_nettype wire

// File: design/l2_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

// Tags and valid flags for every set and way, read one cycle after the index
module l2_tag_array (
    input  wire logic                       clk,
    input  wire logic                       rst_n,

    input  wire logic [`L2_SETS_W-1:0]      rd_index,

    input  wire logic                       wr_en,
    input  wire logic [`L2_SETS_W-1:0]      wr_index,
    input  wire logic [`L2_WAYS-1:0]        wr_way,
    input  wire logic [`L2_TAG_W-1:0]       wr_tag,

    output l2_cache_pkg::l2_way_tags_t      rd_tags
);

    logic [`L2_TAG_W-1:0] tag_mem [`L2_WAYS][`L2_SETS];
    logic [`L2_SETS-1:0][`L2_WAYS-1:0] valid_q;

    logic [`L2_TAG_W-1:0] tag_rd [`L2_WAYS];
    logic [`L2_WAYS-1:0]  valid_rd;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (wr_en && wr_way[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
        end
    end

    // Valid bits only ever get set here; nothing invalidates a line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= valid_q[wr_index] | wr_way;
        end
    end

    //////////////////////////////////////////////////
    // Registered read
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            tag_rd[w] <= tag_mem[w][rd_index];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_rd <= '0;
        end else begin
            valid_rd <= valid_q[rd_index];
        end
    end

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            rd_tags[w].valid = valid_rd[w];
            rd_tags[w].tag   = tag_rd[w];
        end
    end

    // A tag write targets exactly one way
    a_wr_way_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> $onehot(wr_way)
    ) else $error("tag write with wr_way not one-hot");

endmodule

`default_nettype wire

// File: design/l2_victim_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

// Round-robin replacement pointer per set
module l2_victim_select (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`L2_SETS_W-1:0] index,
    input  wire logic                  advance,
    output logic      [`L2_WAYS-1:0]   victim
);

    logic [`L2_SETS-1:0][`L2_WAY_PTR_W-1:0] ptr_q;

    // Pointer wraps naturally from 7 to 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (advance) begin
            ptr_q[index] <= ptr_q[index] + 1'b1;
        end
    end

    // One-hot decode of the current set's pointer
    assign victim = {{(`L2_WAYS-1){1'b0}}, 1'b1} << ptr_q[index];

    // An advance must name a known set
    a_advance_index_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        advance |-> !$isunknown(index)
    ) else $error("pointer advance with unknown set index");

endmodule

`default_nettype wire

// File: design/l2_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

// L2 storage core: request in, tag compare, response one cycle later
module l2_cache_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire logic                    req_valid,
    input  wire l2_cache_pkg::l2_req_t   req,
    input  wire logic [`L2_LINE_W-1:0]   refill_line,

    output logic                         resp_valid,
    output l2_cache_pkg::l2_resp_t       resp
);

    import l2_cache_pkg::*;

    // Stage 1
    logic                  s1_valid;
    l2_req_t               s1_req;
    logic [`L2_LINE_W-1:0] s1_line;

    // Array read results
    l2_way_lines_t rd_lines;
    l2_way_tags_t  rd_tags;

    logic [`L2_WAYS-1:0]   hit_way;
    logic                  hit;
    logic [`L2_LINE_W-1:0] hit_line;
    logic [`L2_WORD_W-1:0] hit_word;

    logic                  is_write;
    logic                  is_refill;
    logic [`L2_WAYS-1:0]   victim;
    logic [`L2_WAYS-1:0]   refill_way;
    l2_data_wr_t           data_wr;

    //////////////////////////////////////////////////
    // Request staging
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_req  <= req;
            s1_line <= refill_line;
        end
    end

    //////////////////////////////////////////////////
    // Tag compare and word extract
    //////////////////////////////////////////////////

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit_way[w] = rd_tags[w].valid && (rd_tags[w].tag == s1_req.addr.tag);
            if (hit_way[w]) begin
                hit_line = hit_line | rd_lines[w];
            end
        end
    end

    assign hit      = |hit_way;
    assign hit_word = hit_line[s1_req.addr.offset*`L2_WORD_W +: `L2_WORD_W];

    assign resp_valid = s1_valid;

    // Word only returned on a read hit
    always_comb begin
        resp.hit  = hit;
        resp.word = (s1_req.op == OP_READ && hit) ? hit_word : '0;
    end

    //////////////////////////////////////////////////
    // Write and refill steering
    //////////////////////////////////////////////////

    assign is_write  = s1_valid && (s1_req.op == OP_WRITE);
    assign is_refill = s1_valid && (s1_req.op == OP_REFILL);

    // Refill reuses the hit way, else takes the victim
    assign refill_way = hit ? hit_way : victim;

    always_comb begin
        data_wr.index   = s1_req.addr.index;
        data_wr.replace = is_refill;
        data_wr.offset  = s1_req.addr.offset;
        data_wr.be      = s1_req.be;
        data_wr.word    = s1_req.wdata;
        data_wr.line    = s1_line;
        if (is_refill) begin
            data_wr.way_we = refill_way;
        end else if (is_write) begin
            data_wr.way_we = hit_way;
        end else begin
            data_wr.way_we = '0;
        end
    end

    //////////////////////////////////////////////////
    // Arrays
    //////////////////////////////////////////////////

    l2_data_array data_i (
        .clk      (clk),
        .rd_index (req.addr.index),
        .wr       (data_wr),
        .rd_lines (rd_lines)
    );

    l2_tag_array tag_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (req.addr.index),
        .wr_en    (is_refill),
        .wr_index (s1_req.addr.index),
        .wr_way   (refill_way),
        .wr_tag   (s1_req.addr.tag),
        .rd_tags  (rd_tags)
    );

    // Pointer only moves when a refill misses
    l2_victim_select victim_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (s1_req.addr.index),
        .advance (is_refill && !hit),
        .victim  (victim)
    );

    // Issue rule: arrays have no forwarding path
    a_req_spacing: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |=> !req_valid
    ) else $error("req_valid high in two consecutive cycles");

endmodule

`default_nettype wire

// File: tb/tb_l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module tb_l2_cache;

    import l2_cache_pkg::*;

    localparam int WORDS      = `L2_LINE_W / `L2_WORD_W;
    localparam int RANDOM_OPS = 1500;
    // About 1600 requests at 2 cycles each, plus reset
    localparam int MAX_CYCLES = 4000;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    l2_req_t               req;
    logic [`L2_LINE_W-1:0] refill_line;
    logic                  resp_valid;
    l2_resp_t              resp;

    // Reference model state
    logic [`L2_TAG_W-1:0]  m_tag   [`L2_SETS][`L2_WAYS];
    logic                  m_valid [`L2_SETS][`L2_WAYS];
    int                    m_ptr   [`L2_SETS];
    logic [`L2_LINE_W-1:0] m_lines [logic [`L2_TAG_W+`L2_SETS_W-1:0]];

    // Prediction for the response in flight
    logic                  exp_hit;
    logic [`L2_WORD_W-1:0] exp_word;

    int     errors;
    int     req_count;
    int     resp_count;
    int     cycle_count;
    integer seed;

    l2_cache_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .refill_line (refill_line),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Response checks
    //////////////////////////////////////////////////

    a_resp_timing: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid == $past(req_valid)
    ) else begin
        errors++;
        $display("error at %0t: resp_valid does not follow req_valid by one cycle", $time);
    end

    a_resp_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid |-> (resp.hit == exp_hit)
    ) else begin
        errors++;
        $display("error at %0t: hit flag %0b, expected %0b", $time, resp.hit, exp_hit);
    end

    a_resp_word: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid |-> (resp.word == exp_word)
    ) else begin
        errors++;
        $display("error at %0t: word %08h, expected %08h", $time, resp.word, exp_word);
    end

    always @(negedge clk) begin
        if (resp_valid) begin
            resp_count++;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("%0d errors, %0d requests checked", errors, req_count);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Model and stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [`L2_LINE_W-1:0] pattern_line(input logic [`L2_WORD_W-1:0] base);
        logic [`L2_LINE_W-1:0] line;
        for (int w = 0; w < WORDS; w++) begin
            line[w*`L2_WORD_W +: `L2_WORD_W] = base + 32'(w) * 32'h0101_0101;
        end
        return line;
    endfunction

    function automatic logic [`L2_LINE_W-1:0] random_line();
        logic [`L2_LINE_W-1:0] line;
        for (int w = 0; w < WORDS; w++) begin
            line[w*`L2_WORD_W +: `L2_WORD_W] = $random(seed);
        end
        return line;
    endfunction

    function automatic logic [`L2_TAG_W-1:0] pool_tag(input int k);
        return `L2_TAG_W'(32'h2A000 ^ (32'(k) * 32'h0C31));
    endfunction

    function automatic logic model_find(input logic [`L2_SETS_W-1:0] index,
                                        input logic [`L2_TAG_W-1:0] tag, output int way);
        logic found;
        found = 1'b0;
        way   = 0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (!found && m_valid[index][w] && m_tag[index][w] == tag) begin
                found = 1'b1;
                way   = w;
            end
        end
        return found;
    endfunction

    // Predict, update the model, issue on a falling edge, then wait for the response
    task automatic send_request(input l2_op_e op, input logic [`L2_TAG_W-1:0] tag,
                                input logic [`L2_SETS_W-1:0] index,
                                input logic [`L2_OFFSET_W-1:0] offset,
                                input logic [`L2_WORD_W-1:0] wdata, input logic [3:0] be,
                                input logic [`L2_LINE_W-1:0] line);
        logic                                hit;
        int                                  way;
        logic [`L2_TAG_W+`L2_SETS_W-1:0]     key;
        logic [`L2_LINE_W-1:0]               line_now;
        key = {tag, index};
        hit = model_find(index, tag, way);
        @(negedge clk);
        exp_hit  = hit;
        exp_word = '0;
        if (op == OP_READ && hit) begin
            line_now = m_lines[key];
            exp_word = line_now[int'(offset)*`L2_WORD_W +: `L2_WORD_W];
        end
        if (op == OP_WRITE && hit) begin
            line_now = m_lines[key];
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    line_now[int'(offset)*`L2_WORD_W + b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            m_lines[key] = line_now;
        end
        if (op == OP_REFILL) begin
            // Miss takes the round-robin victim
            if (!hit) begin
                way          = m_ptr[index];
                m_ptr[index] = (m_ptr[index] + 1) % `L2_WAYS;
            end
            m_valid[index][way] = 1'b1;
            m_tag[index][way]   = tag;
            m_lines[key]        = line;
        end
        req.op           = op;
        req.addr.tag     = tag;
        req.addr.index   = index;
        req.addr.offset  = offset;
        req.addr.byte_off = 2'b00;
        req.wdata        = wdata;
        req.be           = be;
        refill_line      = line;
        req_valid        = 1'b1;
        req_count++;
        @(negedge clk);
        req_valid = 1'b0;
        while (!resp_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic read_all_words(input logic [`L2_TAG_W-1:0] tag,
                                  input logic [`L2_SETS_W-1:0] index);
        for (int o = 0; o < WORDS; o++) begin
            send_request(OP_READ, tag, index, `L2_OFFSET_W'(o), '0, '0, '0);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic check_reset_misses();
        send_request(OP_READ, 22'h0, 4'd0, 4'd0, '0, '0, '0);
        send_request(OP_READ, 22'h3FFFFF, 4'd15, 4'd15, '0, '0, '0);
        send_request(OP_READ, 22'h12345, 4'd5, 4'd7, '0, '0, '0);
        send_request(OP_READ, pool_tag(3), 4'd9, 4'd2, '0, '0, '0);
        send_request(OP_READ, 22'h00ABC, 4'd11, 4'd9, '0, '0, '0);
    endtask

    task automatic check_line_access();
        // Refill two lines of set 5, then a partial write into the first
        send_request(OP_REFILL, 22'h000A1, 4'd5, 4'd0, '0, '0, pattern_line(32'h1000_0000));
        read_all_words(22'h000A1, 4'd5);
        send_request(OP_REFILL, 22'h000B2, 4'd5, 4'd0, '0, '0, pattern_line(32'h2000_0000));
        send_request(OP_WRITE, 22'h000A1, 4'd5, 4'd6, 32'hDEAD_BEEF, 4'b0101, '0);
        read_all_words(22'h000A1, 4'd5);
        read_all_words(22'h000B2, 4'd5);
        // Write miss must leave nothing behind
        send_request(OP_WRITE, 22'h000C3, 4'd5, 4'd2, 32'hFFFF_FFFF, 4'b1111, '0);
        send_request(OP_READ, 22'h000C3, 4'd5, 4'd2, '0, '0, '0);
        send_request(OP_REFILL, 22'h000C3, 4'd5, 4'd0, '0, '0, pattern_line(32'h3000_0000));
        read_all_words(22'h000C3, 4'd5);
    endtask

    task automatic check_eviction();
        for (int k = 0; k < 8; k++) begin
            send_request(OP_REFILL, 22'h300 + 22'(k), 4'd11, 4'd0, '0, '0,
                         pattern_line(32'h5000_0000 + (32'(k) << 16)));
        end
        for (int k = 0; k < 8; k++) begin
            send_request(OP_READ, 22'h300 + 22'(k), 4'd11, 4'(k), '0, '0, '0);
        end
        // Ninth tag takes way 0
        send_request(OP_REFILL, 22'h308, 4'd11, 4'd0, '0, '0, pattern_line(32'h5800_0000));
        for (int k = 0; k < 9; k++) begin
            send_request(OP_READ, 22'h300 + 22'(k), 4'd11, 4'd3, '0, '0, '0);
        end
        // Refill of a resident tag leaves the pointer at way 1
        send_request(OP_REFILL, 22'h302, 4'd11, 4'd0, '0, '0, pattern_line(32'h6200_0000));
        send_request(OP_REFILL, 22'h309, 4'd11, 4'd0, '0, '0, pattern_line(32'h6900_0000));
        send_request(OP_READ, 22'h301, 4'd11, 4'd1, '0, '0, '0);
        send_request(OP_READ, 22'h302, 4'd11, 4'd5, '0, '0, '0);
        send_request(OP_READ, 22'h309, 4'd11, 4'd9, '0, '0, '0);
    endtask

    task automatic run_random_mix();
        logic [`L2_SETS_W-1:0] sets [3];
        int                    pick;
        l2_op_e                op;
        sets[0] = 4'd3;
        sets[1] = 4'd9;
        sets[2] = 4'd14;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            pick = int'($unsigned($random(seed)) % 10);
            if (pick < 4) begin
                op = OP_READ;
            end else if (pick < 7) begin
                op = OP_WRITE;
            end else begin
                op = OP_REFILL;
            end
            send_request(op, pool_tag(int'($unsigned($random(seed)) % 20)),
                         sets[$unsigned($random(seed)) % 3], 4'($random(seed)),
                         $random(seed), 4'($random(seed)), random_line());
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        refill_line = '0;
        exp_hit     = 1'b0;
        exp_word    = '0;
        errors      = 0;
        req_count   = 0;
        resp_count  = 0;
        cycle_count = 0;
        seed        = 22;
        for (int s = 0; s < `L2_SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < `L2_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_reset_misses();
        check_line_access();
        check_eviction();
        run_random_mix();

        @(negedge clk);
        if (resp_count != req_count) begin
            errors++;
            $display("%0d requests were issued but %0d responses came back",
                     req_count, resp_count);
        end
        $display("%0d errors, %0d requests checked", errors, req_count);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/l2_cache_pkg.sv
design/bram_bytewrite.sv
design/l2_data_array.sv
design/l2_tag_array.sv
design/l2_victim_select.sv
design/l2_cache_top.sv
tb/tb_l2_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the L2 cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_l2_cache \
    --Mdir obj_dir -o tb_sim \
    -f flist.f

sim_out="$(./obj_dir/tb_sim)"
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
